// ==== common/nocPkg.sv ====
package nocPkg;

  // Router inputs, one queue each
  localparam int numPorts = 5;

  // Width of the length field in a header flit
  localparam int lengthWidth = 12;

  // Input index, also used to tag the source of an output flit
  typedef enum logic [2:0]
  {
    portL = 3'd0,
    portN = 3'd1,
    portE = 3'd2,
    portW = 3'd3,
    portS = 3'd4
  } portIndex;

  // Flit id field, a header is 1
  typedef enum logic [2:0]
  {
    flitIdle = 3'd0,
    flitHead = 3'd1,
    flitBody = 3'd2,
    flitTail = 3'd3
  } flitKind;

  // One-hot arbiter state, bit 0 is idle and bit i+1 grants input i
  typedef enum logic [5:0]
  {
    stIdle   = 6'b000001,
    stGrantL = 6'b000010,
    stGrantN = 6'b000100,
    stGrantE = 6'b001000,
    stGrantW = 6'b010000,
    stGrantS = 6'b100000
  } arbState;

endpackage

// ==== common/flitIf.sv ====
`timescale 1ns/1ps

// Head of one input queue, seen by the arbiter and the output mux
interface flitIf #(
  parameter int flitWidth = 16
);

  logic [flitWidth-1:0]             data;
  nocPkg::flitKind                  kind;
  logic [nocPkg::lengthWidth-1:0]   length;
  logic                             valid;
  // One-cycle pulse that removes the head
  logic                             pop;

  modport queue (output data, output kind, output length, output valid, input pop);

  modport arbiter (input kind, input length, input valid, output pop);

  modport mux (input data, input kind);

endinterface

// ==== rtl/holdTimer.sv ====
`timescale 1ns/1ps

module holdTimer (
  input  logic                           clk,
  input  logic                           rst,
  input  nocPkg::flitKind                headKind,
  input  logic [nocPkg::lengthWidth-1:0] headLength,
  input  logic                           run,
  output logic                           timesUp
);

  logic [nocPkg::lengthWidth-1:0] budget;
  logic [nocPkg::lengthWidth-1:0] count;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      budget <= '0;
      count  <= '0;
    end
    else
    begin
      // A header at the queue head sets the budget for its grant
      if (headKind == nocPkg::flitHead)
      begin
        budget <= headLength;
      end
      if (run)
      begin
        count <= count + 1'b1;
      end
      else
      begin
        count <= '0;
      end
    end
  end

  assign timesUp = (count == budget);

endmodule

// ==== arbiter/outputArbiter.sv ====
`timescale 1ns/1ps

module outputArbiter (
  input  logic            clk,
  input  logic            rst,
  flitIf.arbiter          heads [nocPkg::numPorts],
  output nocPkg::arbState grant
);

  nocPkg::arbState               state;
  nocPkg::arbState               nextState;
  logic [nocPkg::numPorts-1:0]   valid;
  logic [nocPkg::numPorts-1:0]   timesUp;
  logic [nocPkg::numPorts-1:0]   popVec;
  logic                          granted;
  int                            curIdx;

  // First requesting input in circular order beginning at first
  function automatic nocPkg::arbState pickFrom(
    input int                          first,
    input logic [nocPkg::numPorts-1:0] req
  );
    int              idx;
    nocPkg::arbState pick;
    pick = nocPkg::stIdle;
    // Walk backwards so the earliest requester in order is kept
    for (int k = nocPkg::numPorts - 1; k >= 0; k--)
    begin
      idx = (first + k) % nocPkg::numPorts;
      if (req[idx])
      begin
        pick = nocPkg::arbState'(6'b000010 << idx);
      end
    end
    return pick;
  endfunction

  for (genvar i = 0; i < nocPkg::numPorts; i++)
  begin : genPort
    assign valid[i]     = heads[i].valid;
    assign heads[i].pop = popVec[i];

    // Timer runs in exactly the cycles that pop this input
    holdTimer timer (
      .clk       (clk),
      .rst       (rst),
      .headKind  (heads[i].kind),
      .headLength(heads[i].length),
      .run       (popVec[i]),
      .timesUp   (timesUp[i])
    );
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state <= nocPkg::stIdle;
    end
    else
    begin
      state <= nextState;
    end
  end

  // Which input the current state serves
  always_comb
  begin
    granted = 1'b1;
    curIdx  = 0;
    case (state)
      nocPkg::stGrantL:
      begin
        curIdx = 0;
      end
      nocPkg::stGrantN:
      begin
        curIdx = 1;
      end
      nocPkg::stGrantE:
      begin
        curIdx = 2;
      end
      nocPkg::stGrantW:
      begin
        curIdx = 3;
      end
      nocPkg::stGrantS:
      begin
        curIdx = 4;
      end
      default:
      begin
        granted = 1'b0;
      end
    endcase
  end

  always_comb
  begin
    popVec = '0;
    if (!granted)
    begin
      // Fixed priority L, N, E, W, S out of idle
      nextState = pickFrom(0, valid);
    end
    else if (valid[curIdx] && !timesUp[curIdx])
    begin
      popVec[curIdx] = 1'b1;
      nextState      = state;
    end
    else
    begin
      // Rotate, the current input comes last
      nextState = pickFrom(curIdx + 1, valid);
    end
  end

  assign grant = state;

endmodule

// ==== rtl/flitQueue.sv ====
`timescale 1ns/1ps

module flitQueue #(
  parameter int flitWidth  = 16,
  parameter int queueDepth = 4
) (
  input  logic                           clk,
  input  logic                           rst,
  input  logic [flitWidth-1:0]           wrData,
  input  nocPkg::flitKind                wrKind,
  input  logic [nocPkg::lengthWidth-1:0] wrLength,
  input  logic                           wrValid,
  output logic                           full,
  flitIf.queue                           head
);

  localparam int ptrWidth = $clog2(queueDepth);

  logic [flitWidth-1:0]           dataMem   [queueDepth];
  nocPkg::flitKind                kindMem   [queueDepth];
  logic [nocPkg::lengthWidth-1:0] lengthMem [queueDepth];

  logic [ptrWidth-1:0] wrPtr;
  logic [ptrWidth-1:0] rdPtr;
  logic [ptrWidth:0]   count;
  logic                doWrite;
  logic                doPop;

  assign full    = (count == queueDepth[ptrWidth:0]);
  assign doWrite = wrValid && !full;
  assign doPop   = head.pop && head.valid;

  always_ff @(posedge clk)
  begin
    if (doWrite)
    begin
      dataMem[wrPtr]   <= wrData;
      kindMem[wrPtr]   <= wrKind;
      lengthMem[wrPtr] <= wrLength;
    end
  end

  // Pointers wrap naturally since the depth is a power of two
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end
    else
    begin
      if (doWrite)
      begin
        wrPtr <= wrPtr + 1'b1;
      end
      if (doPop)
      begin
        rdPtr <= rdPtr + 1'b1;
      end
      count <= count + doWrite - doPop;
    end
  end

  assign head.data   = dataMem[rdPtr];
  assign head.kind   = kindMem[rdPtr];
  assign head.length = lengthMem[rdPtr];
  assign head.valid  = (count != '0);

endmodule

// ==== rtl/outputMux.sv ====
`timescale 1ns/1ps

module outputMux #(
  parameter int flitWidth = 16
) (
  input  logic                        clk,
  input  logic                        rst,
  flitIf.mux                          heads [nocPkg::numPorts],
  input  nocPkg::arbState             grant,
  input  logic [nocPkg::numPorts-1:0] popped,
  output logic [flitWidth-1:0]        outData,
  output nocPkg::flitKind             outKind,
  output nocPkg::portIndex            outSource,
  output logic                        outValid
);

  logic [flitWidth-1:0] headData [nocPkg::numPorts];
  nocPkg::flitKind      headKind [nocPkg::numPorts];
  nocPkg::portIndex     source;

  for (genvar i = 0; i < nocPkg::numPorts; i++)
  begin : genHead
    assign headData[i] = heads[i].data;
    assign headKind[i] = heads[i].kind;
  end

  // One-hot grant to input index
  always_comb
  begin
    case (grant)
      nocPkg::stGrantN: source = nocPkg::portN;
      nocPkg::stGrantE: source = nocPkg::portE;
      nocPkg::stGrantW: source = nocPkg::portW;
      nocPkg::stGrantS: source = nocPkg::portS;
      default:          source = nocPkg::portL;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      outValid <= 1'b0;
    end
    else
    begin
      outValid <= |popped;
    end
  end

  always_ff @(posedge clk)
  begin
    if (|popped)
    begin
      outData   <= headData[source];
      outKind   <= headKind[source];
      outSource <= source;
    end
  end

endmodule

// ==== rtl/routerOutputPort.sv ====
`timescale 1ns/1ps

module routerOutputPort #(
  parameter int flitWidth  = 16,
  parameter int queueDepth = 4
) (
  input  logic                                                 clk,
  input  logic                                                 rst,
  input  logic [nocPkg::numPorts-1:0][flitWidth-1:0]           inData,
  input  nocPkg::flitKind [nocPkg::numPorts-1:0]               inKind,
  input  logic [nocPkg::numPorts-1:0][nocPkg::lengthWidth-1:0] inLength,
  input  logic [nocPkg::numPorts-1:0]                          inValid,
  output logic [nocPkg::numPorts-1:0]                          inFull,
  output logic [flitWidth-1:0]                                 outData,
  output nocPkg::flitKind                                      outKind,
  output nocPkg::portIndex                                     outSource,
  output logic                                                 outValid
);

  flitIf #(.flitWidth(flitWidth)) heads [nocPkg::numPorts] ();

  nocPkg::arbState             grant;
  logic [nocPkg::numPorts-1:0] popped;

  // One queue per input, in portIndex order
  for (genvar i = 0; i < nocPkg::numPorts; i++)
  begin : genQueue
    flitQueue #(
      .flitWidth (flitWidth),
      .queueDepth(queueDepth)
    ) queue (
      .clk     (clk),
      .rst     (rst),
      .wrData  (inData[i]),
      .wrKind  (inKind[i]),
      .wrLength(inLength[i]),
      .wrValid (inValid[i]),
      .full    (inFull[i]),
      .head    (heads[i])
    );

    assign popped[i] = heads[i].pop;
  end

  outputArbiter arbiter (
    .clk  (clk),
    .rst  (rst),
    .heads(heads),
    .grant(grant)
  );

  outputMux #(
    .flitWidth(flitWidth)
  ) mux (
    .clk      (clk),
    .rst      (rst),
    .heads    (heads),
    .grant    (grant),
    .popped   (popped),
    .outData  (outData),
    .outKind  (outKind),
    .outSource(outSource),
    .outValid (outValid)
  );

endmodule

// ==== tests/tbTasks.svh ====
// Writes one packet, waiting on the falling edge while the queue is full
task automatic sendPacket(input int port, input int length, input int flits);
  for (int f = 0; f < flits; f++)
  begin
    @(negedge clk);
    inValid[port] = 1'b0;
    while (inFull[port])
    begin
      @(negedge clk);
    end
    serial++;
    inData[port]        = flitWidth'($urandom);
    inData[port][7:0]   = serial[7:0];
    inLength[port]      = length[nocPkg::lengthWidth-1:0];
    if (f == 0)
    begin
      inKind[port] = nocPkg::flitHead;
    end
    else if (f == flits - 1)
    begin
      inKind[port] = nocPkg::flitTail;
    end
    else
    begin
      inKind[port] = nocPkg::flitBody;
    end
    inValid[port] = 1'b1;
  end
  @(negedge clk);
  inValid[port] = 1'b0;
endtask

// Waits until every expected flit has left the output
task automatic drain();
  int pending;
  do
  begin
    @(negedge clk);
    pending = 0;
    for (int p = 0; p < np; p++)
    begin
      pending += sbData[p].size();
    end
  end
  while (pending != 0);
  repeat (4) @(negedge clk);
endtask

task automatic reportTest(input string name, input int errorsBefore);
  testsRun++;
  if (errors == errorsBefore)
  begin
    $display("test %s: ok", name);
  end
  else
  begin
    testsFailed++;
    $display("test %s: %0d errors", name, errors - errorsBefore);
  end
endtask

task automatic runSequence();
  int e0;
  int edges;
  e0 = errors;
  repeat (2) @(negedge clk);
  reportTest("reset", e0);

  e0 = errors;
  sendPacket(nocPkg::portS, 6, 6);
  drain();
  reportTest("order and integrity", e0);

  e0    = errors;
  edges = 0;
  fork
    sendPacket(nocPkg::portL, 2, 2);
    sendPacket(nocPkg::portN, 2, 2);
    begin
      @(negedge clk);
      do
      begin
        @(posedge clk);
        edges++;
        @(negedge clk);
      end
      while (!outValid);
      assert (edges == 3)
      else
      begin
        $display("first output flit appeared %0d edges after the write edge, not 2",
                 edges - 1);
        errors++;
      end
      assert (outSource == nocPkg::portL)
      else
      begin
        $display("error outSource expected %h got %h", nocPkg::portL, outSource);
        errors++;
      end
    end
  join
  drain();
  reportTest("idle priority", e0);

  e0          = errors;
  checkBudget = 1'b1;
  runN        = 0;
  fork
    sendPacket(nocPkg::portN, 3, 8);
    sendPacket(nocPkg::portE, 6, 6);
  join
  drain();
  checkBudget = 1'b0;
  reportTest("budget and rotation", e0);

  e0 = errors;
  fork
    sendPacket(nocPkg::portL, 12, 12);
    begin
      repeat (3) @(negedge clk);
      sendPacket(nocPkg::portW, queueDepth, queueDepth);
    end
  join
  assert (inFull[nocPkg::portW])
  else
  begin
    $display("error inFull[W] expected 1 got %h", inFull[nocPkg::portW]);
    errors++;
  end
  do
  begin
    @(negedge clk);
  end
  while (!(outValid && outSource == nocPkg::portW));
  assert (!inFull[nocPkg::portW])
  else
  begin
    $display("error inFull[W] expected 0 got %h", inFull[nocPkg::portW]);
    errors++;
  end
  drain();
  reportTest("overflow flag", e0);

  e0 = errors;
  for (int p = 0; p < np; p++)
  begin
    fork
      automatic int port = p;
      begin
        int len;
        for (int k = 0; k < 4; k++)
        begin
          len = $urandom_range(1, 4);
          sendPacket(port, len, len);
        end
      end
    join_none
  end
  wait fork;
  drain();
  reportTest("random load", e0);
endtask

// ==== tests/tbRouterOutputPort.sv ====
`timescale 1ns/1ps

module tbRouterOutputPort;

  localparam int flitWidth  = 16;
  localparam int queueDepth = 4;
  localparam int maxCycles  = 2000;
  localparam int np         = nocPkg::numPorts;

  logic                                          clk;
  logic                                          rst;
  logic [np-1:0][flitWidth-1:0]                  inData;
  nocPkg::flitKind [np-1:0]                      inKind;
  logic [np-1:0][nocPkg::lengthWidth-1:0]        inLength;
  logic [np-1:0]                                 inValid;
  logic [np-1:0]                                 inFull;
  logic [flitWidth-1:0]                          outData;
  nocPkg::flitKind                               outKind;
  nocPkg::portIndex                              outSource;
  logic                                          outValid;

  // Expected flits per input, in write order
  logic [flitWidth-1:0] sbData [np][$];
  nocPkg::flitKind      sbKind [np][$];

  int   errors;
  int   testsRun;
  int   testsFailed;
  int   cycles;
  int   serial;
  int   runN;
  int   skips [np];
  int   lastSrc;
  bit   checkBudget;
  logic rstLast;
  logic rstPrev;

  routerOutputPort #(
    .flitWidth (flitWidth),
    .queueDepth(queueDepth)
  ) DUT (
    .clk      (clk),
    .rst      (rst),
    .inData   (inData),
    .inKind   (inKind),
    .inLength (inLength),
    .inValid  (inValid),
    .inFull   (inFull),
    .outData  (outData),
    .outKind  (outKind),
    .outSource(outSource),
    .outValid (outValid)
  );

  always #20 clk = ~clk;

  // Scoreboard and checks, sampled on the rising edge
  always @(posedge clk)
  begin
    int src;
    cycles++;
    if (cycles >= maxCycles)
    begin
      $display("timeout: run did not finish within %0d cycles", maxCycles);
      $display("*** TEST FAILED ***");
      $finish;
    end
    else
    begin
      if (rstLast || rstPrev)
      begin
        assert (!outValid && inFull == '0)
        else
        begin
          $display("error outValid/inFull expected 0/00 got %h/%h", outValid, inFull);
          errors++;
        end
      end
      rstPrev = rstLast;
      rstLast = rst;
      for (int p = 0; p < np; p++)
      begin
        if (!rst && inValid[p] && !inFull[p])
        begin
          sbData[p].push_back(inData[p]);
          sbKind[p].push_back(inKind[p]);
        end
      end
      if (outValid)
      begin
        src = int'(outSource);
        if (src != lastSrc)
        begin
          for (int p = 0; p < np; p++)
          begin
            if (p != src && sbData[p].size() > 0)
            begin
              skips[p]++;
            end
            assert (skips[p] <= np)
            else
            begin
              $display("input %0d waited through too many grants", p);
              errors++;
            end
          end
          skips[src] = 0;
          lastSrc    = src;
        end
        if (src == int'(nocPkg::portN))
        begin
          runN++;
        end
        else if (src == int'(nocPkg::portE))
        begin
          runN = 0;
        end
        assert (!(checkBudget && sbData[nocPkg::portE].size() > 0 && runN > 3))
        else
        begin
          $display("input N kept the output beyond its budget of 3 flits");
          errors++;
        end
        assert (sbData[src].size() > 0)
        else
        begin
          $display("output flit from input %0d that was never written", src);
          errors++;
        end
        if (sbData[src].size() > 0)
        begin
          assert (outData == sbData[src][0])
          else
          begin
            $display("error outData expected %h got %h", sbData[src][0], outData);
            errors++;
          end
          assert (outKind == sbKind[src][0])
          else
          begin
            $display("error outKind expected %h got %h", sbKind[src][0], outKind);
            errors++;
          end
          void'(sbData[src].pop_front());
          void'(sbKind[src].pop_front());
        end
      end
    end
  end

  `include "tbTasks.svh"

  initial
  begin
    clk         = 1'b0;
    rst         = 1'b1;
    rstLast     = 1'b0;
    rstPrev     = 1'b0;
    inData      = '0;
    inLength    = '0;
    inValid     = '0;
    errors      = 0;
    testsRun    = 0;
    testsFailed = 0;
    cycles      = 0;
    serial      = 0;
    runN        = 0;
    lastSrc     = -1;
    checkBudget = 1'b0;
    for (int p = 0; p < np; p++)
    begin
      skips[p]  = 0;
      inKind[p] = nocPkg::flitIdle;
    end
    void'($urandom(21));
    repeat (8) @(negedge clk);
    rst = 1'b0;
    runSequence();
    $display("tests run %0d, failed %0d, errors %0d", testsRun, testsFailed, errors);
    if (errors == 0)
    begin
      $display("*** TEST PASSED ***");
    end
    else
    begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

// ==== filelist.f ====
common/nocPkg.sv
common/flitIf.sv
rtl/holdTimer.sv
arbiter/outputArbiter.sv
rtl/flitQueue.sv
rtl/outputMux.sv
rtl/routerOutputPort.sv
+incdir+tests
tests/tbRouterOutputPort.sv
